//--- Makefile
# Verilator build and run for the LC4 pipeline testbench

VERILATOR ?= verilator
TOP       ?= tb_lc4_core
FILELIST  ?= lc4_pipe.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TESTBENCH PASSED

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) design/*.sv bench/*.sv bench/*.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the last stage of the pipe decides the exit status
run: compile
	./$(SIM_BIN) | tee /dev/stderr | grep -F -x "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(OBJ_DIR)

//--- bench/tb_lc4_model.svh
`ifndef TB_LC4_MODEL_SVH
`define TB_LC4_MODEL_SVH

localparam int    PROG_SLOTS = 32;
localparam int    HALT_IDX   = 27;
localparam word_t HALT_PC    = LC4_RESET_PC + word_t'(HALT_IDX);

typedef struct {
   word_t pc;
   insn_t insn;
   logic  we;
   rsel_t wsel;
   word_t data;
   logic  after_load;   // reads the register loaded just before
} exp_retire_t;

insn_t       prog [PROG_SLOTS];
exp_retire_t exp_q [$];
dmem_req_t   exp_st [$];

// initial data memory content, mixes every address bit
function automatic word_t fill_word(input word_t a);
   return {a[7:0], a[15:8]} ^ 16'hc35a;
endfunction

function automatic word_t sext(input word_t v, input int bits);
   word_t w;
   w = v;
   for (int i = bits; i < LC4_XLEN; i++) begin
      w[i] = v[bits-1];
   end
   return w;
endfunction

function automatic insn_t enc_alu(input logic [3:0] op, input int d, input int s,
                                  input logic [2:0] sub, input int t);
   return {op, 3'(d), 3'(s), sub, 3'(t)};
endfunction

function automatic insn_t enc_imm5(input logic [3:0] op, input int d, input int s,
                                   input int imm);
   return {op, 3'(d), 3'(s), 1'b1, 5'(imm)};
endfunction

function automatic insn_t enc_const(input int d, input int imm);
   return {OP_CONST, 3'(d), 9'(imm)};
endfunction

function automatic insn_t enc_mem(input logic [3:0] op, input int r, input int base,
                                  input int off);
   return {op, 3'(r), 3'(base), 6'(off)};
endfunction

function automatic insn_t enc_br(input logic [2:0] nzp, input int off);
   return {OP_BR, nzp, 9'(off)};
endfunction

function automatic insn_t enc_jmp(input int off);
   return {OP_JMP, 1'b1, 11'(off)};
endfunction

task automatic load_program();
   for (int i = 0; i < PROG_SLOTS; i++) begin
      prog[i] = '0;   // NOP
   end
   prog[0]  = enc_const(1, int'(9'($urandom)));
   prog[1]  = enc_const(2, int'(9'($urandom)));
   prog[2]  = enc_alu(OP_ARITH, 3, 1, 3'b000, 2);   // needs M and W forwarding
   prog[3]  = enc_alu(OP_ARITH, 4, 3, 3'b010, 1);
   prog[4]  = enc_alu(OP_LOGIC, 5, 4, 3'b011, 3);
   prog[5]  = enc_imm5(OP_ARITH, 5, 5, -3);
   prog[6]  = enc_alu(OP_LOGIC, 6, 5, 3'b001, 0);
   prog[7]  = enc_alu(OP_LOGIC, 6, 6, 3'b010, 2);
   prog[8]  = enc_imm5(OP_LOGIC, 7, 6, 15);
   prog[9]  = enc_const(0, 'h40);                  // data base
   prog[10] = enc_mem(OP_STR, 3, 0, 2);
   prog[11] = enc_mem(OP_LDR, 1, 0, 2);
   prog[12] = enc_alu(OP_ARITH, 2, 1, 3'b000, 1);   // load-use
   prog[13] = enc_mem(OP_LDR, 4, 0, 5);
   prog[14] = enc_mem(OP_STR, 4, 0, 6);             // data straight from the load
   prog[15] = enc_alu(OP_ARITH, 3, 1, 3'b010, 1);   // zero
   prog[16] = enc_br(3'b010, 2);                    // taken
   prog[17] = enc_const(7, 1);
   prog[18] = enc_const(7, 2);
   prog[19] = enc_br(3'b101, 5);                    // not taken
   prog[20] = enc_br(3'b000, 0);
   prog[21] = enc_jmp(2);
   prog[22] = enc_const(6, 3);
   prog[23] = enc_const(6, 4);
   prog[24] = enc_mem(OP_LDR, 6, 0, 2);
   prog[25] = enc_br(3'b100, 1);                    // flags of the load
   prog[26] = enc_imm5(OP_ARITH, 7, 6, 1);
   prog[HALT_IDX] = enc_jmp(-1);                    // jump to self
endtask

// in-order LC4 subset, one instruction per step until the self jump
task automatic run_model();
   word_t       regs [LC4_NREG];
   word_t       mem [word_t];
   nzp_t        flags;
   word_t       pc, npc, a, res, idx;
   insn_t       in;
   rsel_t       d, s, t, prev_wsel;
   logic        we, rd_s, rd_t, prev_ld, done;
   exp_retire_t e;
   for (int i = 0; i < LC4_NREG; i++) begin
      regs[i] = '0;
   end
   flags   = 3'b010;
   pc      = LC4_RESET_PC;
   prev_ld = 1'b0;
   prev_wsel = '0;
   done    = 1'b0;
   for (int step = 0; step < 100 && !done; step++) begin
      idx  = pc - LC4_RESET_PC;
      in   = prog[idx[4:0]];
      d    = in[11:9];
      s    = in[8:6];
      t    = in[2:0];
      npc  = pc + 16'd1;
      we   = 1'b0;
      res  = '0;
      rd_s = 1'b0;
      rd_t = 1'b0;
      case (in[15:12])
         OP_ARITH: begin
            rd_s = 1'b1;
            rd_t = !in[5];
            we   = 1'b1;
            if (in[5])
               res = regs[s] + sext(in, 5);
            else if (in[5:3] == 3'b010)
               res = regs[s] - regs[t];
            else
               res = regs[s] + regs[t];
         end
         OP_LOGIC: begin
            rd_s = 1'b1;
            rd_t = !in[5] && in[4:3] != 2'b01;
            we   = 1'b1;
            if (in[5])
               res = regs[s] & sext(in, 5);
            else begin
               case (in[4:3])
                  2'b00:   res = regs[s] & regs[t];
                  2'b01:   res = ~regs[s];
                  2'b10:   res = regs[s] | regs[t];
                  default: res = regs[s] ^ regs[t];
               endcase
            end
         end
         OP_CONST: begin
            we  = 1'b1;
            res = sext(in, 9);
         end
         OP_LDR: begin
            rd_s = 1'b1;
            we   = 1'b1;
            a    = regs[s] + sext(in, 6);
            res  = mem.exists(a) ? mem[a] : fill_word(a);
         end
         OP_STR: begin
            rd_s   = 1'b1;
            a      = regs[s] + sext(in, 6);
            mem[a] = regs[d];
            exp_st.push_back('{addr: a, we: 1'b1, wdata: regs[d]});
         end
         OP_BR: if (|(in[11:9] & flags)) npc = pc + 16'd1 + sext(in, 9);
         OP_JMP: npc = in[11] ? pc + 16'd1 + sext(in, 11) : regs[s];
         default: ;
      endcase
      e.after_load = prev_ld && ((rd_s && s == prev_wsel) || (rd_t && t == prev_wsel));
      prev_ld   = in[15:12] == OP_LDR;
      prev_wsel = d;
      if (we) begin
         regs[d] = res;
         flags   = {res[15], res == 16'd0, !res[15] && res != 16'd0};
      end
      e.pc   = pc;
      e.insn = in;
      e.we   = we;
      e.wsel = d;
      e.data = we ? res : '0;
      exp_q.push_back(e);
      done = npc == pc;
      pc   = npc;
   end
endtask

`endif

//--- bench/tb_lc4_core.sv
`timescale 1ns/100ps

module tb_lc4_core import lc4_pkg::*; ();

   localparam int RETIRE_TIMEOUT = 200;

   logic      gwe;
   logic      i_arst_n;
   insn_t     i_imem_insn;
   word_t     o_imem_addr;
   word_t     i_dmem_data;
   dmem_req_t o_dmem;
   retire_t   o_retire;

   word_t dmem [65536];
   word_t imem_idx;
   int    cyc;
   int    ret_idx;
   int    st_idx;
   int    last_ret_cyc;
   int    val_errs;
   int    other_errs;
   logic  halted;

`include "tb_lc4_model.svh"

   // both memories answer in the same cycle
   assign imem_idx    = o_imem_addr - LC4_RESET_PC;
   assign i_imem_insn = (imem_idx < 16'(PROG_SLOTS)) ? prog[imem_idx[4:0]] : '0;
   assign i_dmem_data = dmem[o_dmem.addr];

   lc4_core i_lc4_core (
      .gwe         (gwe),
      .i_arst_n    (i_arst_n),
      .i_imem_insn (i_imem_insn),
      .o_imem_addr (o_imem_addr),
      .i_dmem_data (i_dmem_data),
      .o_dmem      (o_dmem),
      .o_retire    (o_retire)
   );

   initial gwe = 1'b0;
   always #4 gwe = ~gwe;

   task automatic value_fail(input string sig, input word_t exp, input word_t got);
      val_errs++;
      $display("FAIL %0t %s expected %h got %h", $time, sig, exp, got);
   endtask

   task automatic other_fail(input string what);
      other_errs++;
      $display("ERROR %0t %s", $time, what);
   endtask

   task automatic check_retire();
      exp_retire_t e;
      if (halted && o_retire.pc == HALT_PC)
         return;   // halt loop keeps retiring
      if (ret_idx >= exp_q.size()) begin
         other_fail($sformatf("unexpected retire at pc %h", o_retire.pc));
         return;
      end
      e = exp_q[ret_idx];
      assert (o_retire.pc == e.pc) else value_fail("o_retire.pc", e.pc, o_retire.pc);
      assert (o_retire.insn == e.insn)
         else value_fail("o_retire.insn", e.insn, o_retire.insn);
      assert (o_retire.regfile_we == e.we)
         else value_fail("o_retire.regfile_we", word_t'(e.we), word_t'(o_retire.regfile_we));
      if (e.we) begin
         assert (o_retire.wsel == e.wsel)
            else value_fail("o_retire.wsel", word_t'(e.wsel), word_t'(o_retire.wsel));
         assert (o_retire.data == e.data)
            else value_fail("o_retire.data", e.data, o_retire.data);
      end
      if (e.after_load)
         assert (cyc - last_ret_cyc > 1)
            else other_fail("no bubble between a load and the instruction using it");
      last_ret_cyc = cyc;
      if (o_retire.pc == HALT_PC)
         halted = 1'b1;
      ret_idx++;
   endtask

   task automatic check_store();
      if (st_idx >= exp_st.size()) begin
         other_fail($sformatf("unexpected store to %h", o_dmem.addr));
         return;
      end
      assert (o_dmem.addr == exp_st[st_idx].addr)
         else value_fail("o_dmem.addr", exp_st[st_idx].addr, o_dmem.addr);
      assert (o_dmem.wdata == exp_st[st_idx].wdata)
         else value_fail("o_dmem.wdata", exp_st[st_idx].wdata, o_dmem.wdata);
      st_idx++;
   endtask

   // outputs are sampled before this edge's updates land
   always @(posedge gwe) begin
      if (i_arst_n) begin
         cyc = cyc + 1;
         if (o_retire.valid)
            check_retire();
         if (o_dmem.we) begin
            check_store();
            dmem[o_dmem.addr] <= o_dmem.wdata;
         end
      end
   end

   initial begin
      int waited;
      int seen;
      i_arst_n     = 1'b0;
      cyc          = 0;
      ret_idx      = 0;
      st_idx       = 0;
      last_ret_cyc = 0;
      val_errs     = 0;
      other_errs   = 0;
      halted       = 1'b0;
      void'($urandom(32'h05edb97c));
      for (int a = 0; a < 65536; a++) begin
         dmem[a] = fill_word(word_t'(a));
      end
      load_program();
      run_model();

      repeat (3) @(posedge gwe);
      i_arst_n <= 1'b1;
      @(posedge gwe);
      assert (o_retire.valid == 1'b0)
         else value_fail("o_retire.valid", 16'd0, word_t'(o_retire.valid));
      assert (o_dmem.we == 1'b0) else value_fail("o_dmem.we", 16'd0, word_t'(o_dmem.we));
      assert (o_imem_addr == LC4_RESET_PC)
         else value_fail("o_imem_addr", LC4_RESET_PC, o_imem_addr);

      while (ret_idx < exp_q.size()) begin
         seen   = ret_idx;
         waited = 0;
         while (ret_idx == seen && waited < RETIRE_TIMEOUT) begin
            @(posedge gwe);
            waited++;
         end
         if (ret_idx == seen) begin
            other_fail($sformatf("timeout waiting for retire %0d", seen));
            break;
         end
      end

      // let the halt loop spin, nothing else may retire
      repeat (20) @(posedge gwe);
      assert (ret_idx == exp_q.size())
         else other_fail($sformatf("retired %0d of %0d", ret_idx, exp_q.size()));
      assert (st_idx == exp_st.size())
         else other_fail($sformatf("saw %0d of %0d stores", st_idx, exp_st.size()));

      $display("errors: %0d value, %0d other", val_errs, other_errs);
      if (val_errs + other_errs == 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

//--- design/lc4_core.sv
`timescale 1ns/100ps

module lc4_core import lc4_pkg::*; (
   input  logic      gwe,
   input  logic      i_arst_n,
   input  insn_t     i_imem_insn,
   output word_t     o_imem_addr,
   input  word_t     i_dmem_data,
   output dmem_req_t o_dmem,
   output retire_t   o_retire
);

   fd_t       fd;
   dx_t       dx;
   xm_t       xm;
   logic      stall;      // load-use, from decode
   redirect_t redirect;   // taken branch or jump, from execute
   wb_t       wb;
   nzp_t      cond;

   lc4_fetch u_fetch (
      .gwe         (gwe),
      .i_arst_n    (i_arst_n),
      .i_stall     (stall),
      .i_redirect  (redirect),
      .i_imem_insn (i_imem_insn),
      .o_imem_addr (o_imem_addr),
      .o_fd        (fd)
   );

   lc4_decoder u_decoder (
      .gwe      (gwe),
      .i_arst_n (i_arst_n),
      .i_fd     (fd),
      .i_flush  (redirect.taken),
      .i_wb     (wb),
      .o_stall  (stall),
      .o_dx     (dx)
   );

   lc4_execute u_execute (
      .gwe        (gwe),
      .i_arst_n   (i_arst_n),
      .i_dx       (dx),
      .i_wb       (wb),
      .i_cond     (cond),
      .o_redirect (redirect),
      .o_xm       (xm)
   );

   lc4_result u_result (
      .gwe         (gwe),
      .i_arst_n    (i_arst_n),
      .i_xm        (xm),
      .i_dmem_data (i_dmem_data),
      .o_dmem      (o_dmem),
      .o_cond      (cond),
      .o_wb        (wb),
      .o_retire    (o_retire)
   );

endmodule

//--- design/lc4_decoder.sv
`timescale 1ns/100ps

module lc4_decoder import lc4_pkg::*; (
   input  logic gwe,
   input  logic i_arst_n,
   input  fd_t  i_fd,
   input  logic i_flush,
   input  wb_t  i_wb,
   output logic o_stall,
   output dx_t  o_dx
);

   ctrl_t ctrl;
   word_t rs_data;
   word_t rt_data;
   word_t imm5;
   word_t imm6;
   word_t imm9;
   word_t imm11;
   dx_t   dx_d;

   assign imm5  = {{(LC4_XLEN-5){i_fd.insn[4]}}, i_fd.insn[4:0]};
   assign imm6  = {{(LC4_XLEN-6){i_fd.insn[5]}}, i_fd.insn[5:0]};
   assign imm9  = {{(LC4_XLEN-9){i_fd.insn[8]}}, i_fd.insn[8:0]};
   assign imm11 = {{(LC4_XLEN-11){i_fd.insn[10]}}, i_fd.insn[10:0]};

   // bubbles decode to all-zero control
   always_comb begin
      ctrl       = '0;
      ctrl.r1sel = i_fd.insn[8:6];
      ctrl.wsel  = i_fd.insn[11:9];
      if (i_fd.valid) begin
         unique case (i_fd.insn[15:12])
            OP_ARITH: begin
               // bit 3 set means mul or div, left out as nop
               ctrl.regfile_we = i_fd.insn[5] || !i_fd.insn[3];
               ctrl.r1re       = ctrl.regfile_we;
               ctrl.r2sel      = i_fd.insn[2:0];
               ctrl.r2re       = ctrl.regfile_we && !i_fd.insn[5];
               ctrl.alu_op     = (!i_fd.insn[5] && i_fd.insn[4]) ? SUB : ADD;
               ctrl.imm        = imm5;
            end
            OP_LOGIC: begin
               ctrl.regfile_we = 1'b1;
               ctrl.r1re       = 1'b1;
               ctrl.r2sel      = i_fd.insn[2:0];
               ctrl.r2re       = !i_fd.insn[5] && i_fd.insn[4:3] != 2'b01;   // not NOT
               ctrl.imm        = imm5;
               if (i_fd.insn[5])
                  ctrl.alu_op = AND;
               else begin
                  unique case (i_fd.insn[4:3])
                     2'b00:   ctrl.alu_op = AND;
                     2'b01:   ctrl.alu_op = NOT;
                     2'b10:   ctrl.alu_op = OR;
                     default: ctrl.alu_op = XOR;
                  endcase
               end
            end
            OP_LDR: begin
               ctrl.regfile_we = 1'b1;
               ctrl.r1re       = 1'b1;
               ctrl.is_load    = 1'b1;
               ctrl.alu_op     = ADDR;
               ctrl.imm        = imm6;
            end
            OP_STR: begin
               ctrl.r1re     = 1'b1;
               ctrl.r2sel    = i_fd.insn[11:9];   // data register
               ctrl.r2re     = 1'b1;
               ctrl.is_store = 1'b1;
               ctrl.alu_op   = ADDR;
               ctrl.imm      = imm6;
            end
            OP_CONST: begin
               ctrl.regfile_we = 1'b1;
               ctrl.alu_op     = PASS_IMM;
               ctrl.imm        = imm9;
            end
            OP_BR: begin
               ctrl.is_branch = 1'b1;   // nzp = 000 is the nop
               ctrl.alu_op    = ADDR;
               ctrl.imm       = imm9;
            end
            OP_JMP: begin
               ctrl.is_jump = 1'b1;
               ctrl.alu_op  = ADDR;
               ctrl.r1re    = !i_fd.insn[11];   // JMPR takes rs + 0
               ctrl.imm     = i_fd.insn[11] ? imm11 : '0;
            end
            default: ;
         endcase
      end
      ctrl.nzp_we = ctrl.regfile_we;
   end

   lc4_regfile u_regfile (
      .gwe       (gwe),
      .i_arst_n  (i_arst_n),
      .i_rs      (ctrl.r1sel),
      .i_rt      (ctrl.r2sel),
      .o_rs_data (rs_data),
      .o_rt_data (rt_data),
      .i_wb      (i_wb)
   );

   // load in execute feeding this insn, store data is fixed up in memory
   assign o_stall = o_dx.valid && o_dx.ctrl.is_load &&
                    ((ctrl.r1re && ctrl.r1sel == o_dx.ctrl.wsel) ||
                     (ctrl.r2re && !ctrl.is_store && ctrl.r2sel == o_dx.ctrl.wsel));

   assign dx_d.valid   = i_fd.valid;
   assign dx_d.pc      = i_fd.pc;
   assign dx_d.insn    = i_fd.insn;
   assign dx_d.ctrl    = ctrl;
   assign dx_d.rs_data = rs_data;
   assign dx_d.rt_data = rt_data;

   pipe_reg #(.T_PAYLOAD(dx_t)) u_dx_reg (
      .gwe      (gwe),
      .i_arst_n (i_arst_n),
      .i_hold   (1'b0),
      .i_bubble (i_flush || o_stall),
      .i_d      (dx_d),
      .o_q      (o_dx)
   );

   a_stall_needs_valid: assert property (
      @(posedge gwe) disable iff (!i_arst_n) o_stall |-> i_fd.valid
   );

endmodule

//--- design/lc4_execute.sv
`timescale 1ns/100ps

module lc4_execute import lc4_pkg::*; (
   input  logic      gwe,
   input  logic      i_arst_n,
   input  dx_t       i_dx,
   input  wb_t       i_wb,
   input  nzp_t      i_cond,
   output redirect_t o_redirect,
   output xm_t       o_xm
);

   logic  m_fwd;
   word_t rs_fwd;
   word_t rt_fwd;
   word_t op_b;
   word_t base;
   word_t pc_plus1;
   word_t alu;
   logic  cond_hit;
   xm_t   xm_d;

   // load value is not ready yet in memory, the stall covers that case
   assign m_fwd = o_xm.valid && o_xm.ctrl.regfile_we && !o_xm.ctrl.is_load;

   always_comb begin
      if (m_fwd && o_xm.ctrl.wsel == i_dx.ctrl.r1sel)
         rs_fwd = o_xm.alu;
      else if (i_wb.we && i_wb.wsel == i_dx.ctrl.r1sel)
         rs_fwd = i_wb.data;
      else
         rs_fwd = i_dx.rs_data;
   end

   always_comb begin
      if (m_fwd && o_xm.ctrl.wsel == i_dx.ctrl.r2sel)
         rt_fwd = o_xm.alu;
      else if (i_wb.we && i_wb.wsel == i_dx.ctrl.r2sel)
         rt_fwd = i_wb.data;
      else
         rt_fwd = i_dx.rt_data;
   end

   assign pc_plus1 = i_dx.pc + word_t'(1);
   assign op_b     = i_dx.ctrl.r2re ? rt_fwd : i_dx.ctrl.imm;
   assign base     = i_dx.ctrl.r1re ? rs_fwd : pc_plus1;   // ldr/str/jmpr vs pc-relative

   always_comb begin
      unique case (i_dx.ctrl.alu_op)
         ADD:      alu = rs_fwd + op_b;
         SUB:      alu = rs_fwd - op_b;
         AND:      alu = rs_fwd & op_b;
         OR:       alu = rs_fwd | op_b;
         XOR:      alu = rs_fwd ^ op_b;
         NOT:      alu = ~rs_fwd;
         PASS_IMM: alu = i_dx.ctrl.imm;
         ADDR:     alu = base + i_dx.ctrl.imm;
      endcase
   end

   assign cond_hit = |(i_dx.insn[11:9] & i_cond);

   assign o_redirect.taken  = i_dx.ctrl.is_jump || (i_dx.ctrl.is_branch && cond_hit);
   assign o_redirect.target = alu;

   assign xm_d.valid   = i_dx.valid;
   assign xm_d.pc      = i_dx.pc;
   assign xm_d.insn    = i_dx.insn;
   assign xm_d.ctrl    = i_dx.ctrl;
   assign xm_d.alu     = alu;
   assign xm_d.rt_data = rt_fwd;

   pipe_reg #(.T_PAYLOAD(xm_t)) u_xm_reg (
      .gwe      (gwe),
      .i_arst_n (i_arst_n),
      .i_hold   (1'b0),
      .i_bubble (1'b0),   // the branch itself always moves on
      .i_d      (xm_d),
      .o_q      (o_xm)
   );

   // squashed and stalled slots carry zero control from decode
   a_redirect_valid: assert property (
      @(posedge gwe) disable iff (!i_arst_n) o_redirect.taken |-> i_dx.valid
   );

endmodule

//--- design/lc4_fetch.sv
`timescale 1ns/100ps

module lc4_fetch import lc4_pkg::*; (
   input  logic      gwe,
   input  logic      i_arst_n,
   input  logic      i_stall,
   input  redirect_t i_redirect,
   input  insn_t     i_imem_insn,
   output word_t     o_imem_addr,
   output fd_t       o_fd
);

   word_t pc_q;
   word_t pc_next;
   fd_t   fd_d;

   // redirect first, then load-use hold, else sequential
   always_comb begin
      if (i_redirect.taken)
         pc_next = i_redirect.target;
      else if (i_stall)
         pc_next = pc_q;
      else
         pc_next = pc_q + word_t'(1);
   end

   always_ff @(posedge gwe or negedge i_arst_n) begin
      if (!i_arst_n)
         pc_q <= LC4_RESET_PC;
      else
         pc_q <= pc_next;
   end

   assign o_imem_addr = pc_q;

   assign fd_d.valid = 1'b1;
   assign fd_d.pc    = pc_q;
   assign fd_d.insn  = i_imem_insn;   // imem answers in the same cycle

   pipe_reg #(.T_PAYLOAD(fd_t)) u_fd_reg (
      .gwe      (gwe),
      .i_arst_n (i_arst_n),
      .i_hold   (i_stall),
      .i_bubble (i_redirect.taken),   // younger fetch is on the wrong path
      .i_d      (fd_d),
      .o_q      (o_fd)
   );

   a_reset_pc: assert property (
      @(posedge gwe) $rose(i_arst_n) |-> o_imem_addr == LC4_RESET_PC
   );

endmodule

//--- design/lc4_pkg.sv
package lc4_pkg;

   localparam int LC4_XLEN = 16;
   localparam int LC4_NREG = 8;

   typedef logic [LC4_XLEN-1:0]         word_t;
   typedef logic [LC4_XLEN-1:0]         insn_t;
   typedef logic [$clog2(LC4_NREG)-1:0] rsel_t;
   typedef logic [2:0]                  nzp_t;   // {n, z, p}

   localparam word_t LC4_RESET_PC = 16'h8200;

   // top nibble of the instruction
   localparam logic [3:0] OP_BR    = 4'b0000;
   localparam logic [3:0] OP_ARITH = 4'b0001;
   localparam logic [3:0] OP_LOGIC = 4'b0101;
   localparam logic [3:0] OP_LDR   = 4'b0110;
   localparam logic [3:0] OP_STR   = 4'b0111;
   localparam logic [3:0] OP_CONST = 4'b1001;
   localparam logic [3:0] OP_JMP   = 4'b1100;

   // ADDR is base + imm, base is rs or pc+1
   typedef enum logic [2:0] {
      ADD, SUB, AND, OR, XOR, NOT, PASS_IMM, ADDR
   } alu_op_e;

   typedef struct packed {
      rsel_t   r1sel;
      logic    r1re;
      rsel_t   r2sel;
      logic    r2re;
      rsel_t   wsel;
      logic    regfile_we;
      logic    nzp_we;
      logic    is_load;
      logic    is_store;
      logic    is_branch;
      logic    is_jump;
      alu_op_e alu_op;
      word_t   imm;        // already sign extended
   } ctrl_t;

   typedef struct packed {logic valid; word_t pc; insn_t insn;} fd_t;

   typedef struct packed {
      logic  valid;
      word_t pc;
      insn_t insn;
      ctrl_t ctrl;
      word_t rs_data;
      word_t rt_data;
   } dx_t;

   typedef struct packed {
      logic  valid;
      word_t pc;
      insn_t insn;
      ctrl_t ctrl;
      word_t alu;
      word_t rt_data;   // store data after execute forwarding
   } xm_t;

   typedef struct packed {
      logic  valid;
      word_t pc;
      insn_t insn;
      rsel_t wsel;
      logic  regfile_we;
      word_t result;
   } mw_t;

   typedef struct packed {logic taken; word_t target;} redirect_t;
   typedef struct packed {logic we; rsel_t wsel; word_t data;} wb_t;
   typedef struct packed {word_t addr; logic we; word_t wdata;} dmem_req_t;

   typedef struct packed {
      logic  valid;
      word_t pc;
      insn_t insn;
      logic  regfile_we;
      rsel_t wsel;
      word_t data;
   } retire_t;

endpackage

//--- design/lc4_regfile.sv
`timescale 1ns/100ps

module lc4_regfile import lc4_pkg::*; (
   input  logic  gwe,
   input  logic  i_arst_n,
   input  rsel_t i_rs,
   input  rsel_t i_rt,
   output word_t o_rs_data,
   output word_t o_rt_data,
   input  wb_t   i_wb
);

   word_t regs [LC4_NREG];

   always_ff @(posedge gwe or negedge i_arst_n) begin
      if (!i_arst_n) begin
         for (int i = 0; i < LC4_NREG; i++) begin
            regs[i] <= '0;
         end
      end else if (i_wb.we) begin
         regs[i_wb.wsel] <= i_wb.data;
      end
   end

   // write-through, decode sees the value retiring this cycle
   assign o_rs_data = (i_wb.we && i_wb.wsel == i_rs) ? i_wb.data : regs[i_rs];
   assign o_rt_data = (i_wb.we && i_wb.wsel == i_rt) ? i_wb.data : regs[i_rt];

endmodule

//--- design/lc4_result.sv
`timescale 1ns/100ps

module lc4_result import lc4_pkg::*; (
   input  logic      gwe,
   input  logic      i_arst_n,
   input  xm_t       i_xm,
   input  word_t     i_dmem_data,
   output dmem_req_t o_dmem,
   output nzp_t      o_cond,
   output wb_t       o_wb,
   output retire_t   o_retire
);

   function automatic nzp_t flags_of(input word_t w);
      flags_of = {w[LC4_XLEN-1], w == '0, !w[LC4_XLEN-1] && w != '0};
   endfunction

   word_t st_data;
   word_t result;
   nzp_t  m_flags;
   nzp_t  nzp_q;
   mw_t   mw_d;
   mw_t   mw_q;

   // load right before a store shows up in writeback now
   assign st_data = (o_wb.we && o_wb.wsel == i_xm.ctrl.r2sel) ? o_wb.data : i_xm.rt_data;

   assign o_dmem.addr  = i_xm.alu;
   assign o_dmem.we    = i_xm.ctrl.is_store;
   assign o_dmem.wdata = st_data;

   assign result  = i_xm.ctrl.is_load ? i_dmem_data : i_xm.alu;
   assign m_flags = flags_of(result);

   always_ff @(posedge gwe or negedge i_arst_n) begin
      if (!i_arst_n)
         nzp_q <= 3'b010;   // z
      else if (i_xm.ctrl.nzp_we)
         nzp_q <= m_flags;
   end

   assign o_cond = i_xm.ctrl.nzp_we ? m_flags : nzp_q;   // covers branch right after a load

   assign mw_d.valid      = i_xm.valid;
   assign mw_d.pc         = i_xm.pc;
   assign mw_d.insn       = i_xm.insn;
   assign mw_d.wsel       = i_xm.ctrl.wsel;
   assign mw_d.regfile_we = i_xm.ctrl.regfile_we;
   assign mw_d.result     = result;

   pipe_reg #(.T_PAYLOAD(mw_t)) u_mw_reg (
      .gwe      (gwe),
      .i_arst_n (i_arst_n),
      .i_hold   (1'b0),
      .i_bubble (1'b0),
      .i_d      (mw_d),
      .o_q      (mw_q)
   );

   assign o_wb.we   = mw_q.valid && mw_q.regfile_we;
   assign o_wb.wsel = mw_q.wsel;
   assign o_wb.data = mw_q.result;

   assign o_retire.valid      = mw_q.valid;
   assign o_retire.pc         = mw_q.pc;
   assign o_retire.insn       = mw_q.insn;
   assign o_retire.regfile_we = o_wb.we;
   assign o_retire.wsel       = mw_q.wsel;
   assign o_retire.data       = o_wb.we ? mw_q.result : '0;

   // decode never marks one insn as both load and store
   a_no_load_write: assert property (
      @(posedge gwe) disable iff (!i_arst_n) i_xm.ctrl.is_load |-> !o_dmem.we
   );

endmodule

//--- design/pipe_reg.sv
`timescale 1ns/100ps

module pipe_reg #(
   parameter type T_PAYLOAD = logic
) (
   input  logic     gwe,
   input  logic     i_arst_n,
   input  logic     i_hold,     // keep current contents
   input  logic     i_bubble,   // load an all-zero payload, beats hold
   input  T_PAYLOAD i_d,
   output T_PAYLOAD o_q
);

   always_ff @(posedge gwe or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_q <= '0;
      end else if (i_bubble) begin
         o_q <= '0;
      end else if (!i_hold) begin
         o_q <= i_d;
      end
   end

   // everything feeding a latch must be driven once out of reset
   a_payload_known: assert property (
      @(posedge gwe) disable iff (!i_arst_n) !$isunknown(o_q)
   );

endmodule

//--- lc4_pipe.f
+incdir+bench
design/lc4_pkg.sv
design/pipe_reg.sv
design/lc4_regfile.sv
design/lc4_fetch.sv
design/lc4_decoder.sv
design/lc4_execute.sv
design/lc4_result.sv
design/lc4_core.sv
bench/tb_lc4_core.sv
